// File: hw/mem_ops_pkg.sv
`default_nettype none

package mem_ops_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int DATA_W = 32;

    // Operations seen by the memory stages
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

endpackage

`default_nettype wire

// File: hw/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int VPPN_W = 20;
    localparam int PPN_W = 20;
    localparam int PG_OFS_W = 32 - PPN_W;

    typedef logic [1:0] plv_t;

    typedef enum logic [2:0] {
        FLT_NONE = 3'd0,
        FLT_ADEM = 3'd1,
        FLT_TLBR = 3'd2,
        FLT_PIL  = 3'd3,
        FLT_PIS  = 3'd4,
        FLT_PPI  = 3'd5,
        FLT_PME  = 3'd6
    } fault_e;

    // Physical address, flat or split into page number and offset
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [PPN_W-1:0]    ppn;
            logic [PG_OFS_W-1:0] offset;
        } page;
    } paddr_u;

endpackage

`default_nettype wire

// File: hw/tlb_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_lookup #(
    parameter int ENTRIES = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [31:0]                 vaddr_i,
    input  wire logic                        we_i,
    input  wire logic [$clog2(ENTRIES)-1:0]  idx_i,
    input  wire logic [mmu_pkg::VPPN_W-1:0]  vppn_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]   ppn_i,
    input  wire logic                        v_i,
    input  wire logic                        d_i,
    input  mmu_pkg::plv_t                    plv_i,
    output mmu_pkg::paddr_u                  paddr_o,
    output logic                             found_o,
    output logic                             v_o,
    output logic                             d_o,
    output mmu_pkg::plv_t                    plv_o
);

    logic                       ent_e    [ENTRIES];
    logic [mmu_pkg::VPPN_W-1:0] ent_vppn [ENTRIES];
    logic [mmu_pkg::PPN_W-1:0]  ent_ppn  [ENTRIES];
    logic                       ent_v    [ENTRIES];
    logic                       ent_d    [ENTRIES];
    mmu_pkg::plv_t              ent_plv  [ENTRIES];

    logic [mmu_pkg::VPPN_W-1:0] vpn;
    logic [$clog2(ENTRIES)-1:0] sel;

    assign vpn = vaddr_i[31 -: mmu_pkg::VPPN_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ent_e[i]    <= 1'b0;
                ent_vppn[i] <= '0;
                ent_ppn[i]  <= '0;
                ent_v[i]    <= 1'b0;
                ent_d[i]    <= 1'b0;
                ent_plv[i]  <= '0;
            end
        end else if (we_i) begin
            ent_e[idx_i]    <= 1'b1;
            ent_vppn[idx_i] <= vppn_i;
            ent_ppn[idx_i]  <= ppn_i;
            ent_v[idx_i]    <= v_i;
            ent_d[idx_i]    <= d_i;
            ent_plv[idx_i]  <= plv_i;
        end
    end

    // Lowest matching index wins
    always_comb begin
        found_o = 1'b0;
        sel = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (!found_o && ent_e[i] && ent_vppn[i] == vpn) begin
                found_o = 1'b1;
                sel = i[$clog2(ENTRIES)-1:0];
            end
        end
    end

    assign v_o = found_o & ent_v[sel];
    assign d_o = found_o & ent_d[sel];
    assign plv_o = ent_plv[sel];
    assign paddr_o.page.ppn = found_o ? ent_ppn[sel] : '0;
    assign paddr_o.page.offset = vaddr_i[mmu_pkg::PG_OFS_W-1:0];

endmodule

`default_nettype wire

// File: hw/mem1_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem1_stage #(
    parameter int LINE_BYTES = 16,
    parameter int NSET = 64
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 flush_i,
    input  wire logic                                 advance_i,
    output logic                                      advance_ready_o,
    input  wire logic                                 valid_i,
    input  mem_ops_pkg::op_e                          op_i,
    input  wire logic [31:0]                          vaddr_i,
    input  wire logic [mem_ops_pkg::DATA_W-1:0]       store_data_i,
    input  wire logic [mem_ops_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  wire logic                                 wreg_i,
    input  mmu_pkg::plv_t                             plv_i,
    input  wire logic                                 trans_en_i,
    input  mmu_pkg::paddr_u                           paddr_i,
    input  wire logic                                 found_i,
    input  wire logic                                 tlb_v_i,
    input  wire logic                                 tlb_d_i,
    input  mmu_pkg::plv_t                             tlb_plv_i,
    input  wire logic                                 llbit_i,
    input  wire logic                                 ram_ready_i,
    output logic                                      req_en_o,
    output logic                                      req_we_o,
    output logic [3:0]                                req_be_o,
    output logic [29:0]                               req_addr_o,
    output logic [mem_ops_pkg::DATA_W-1:0]            req_wdata_o,
    output logic                                      s_valid_o,
    output mem_ops_pkg::op_e                          s_op_o,
    output logic [1:0]                                s_addr_lo_o,
    output logic [mem_ops_pkg::REG_ADDR_W-1:0]        s_waddr_o,
    output logic                                      s_wreg_o,
    output logic [mem_ops_pkg::DATA_W-1:0]            s_wdata_o,
    output mmu_pkg::fault_e                           s_fault_o
);

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(NSET);

    logic [31:0]                    phys;
    logic [IDX_W-1:0]               set_idx;
    logic                           load_op;
    logic                           store_op;
    logic                           access;
    mem_ops_pkg::size_e             size;
    mmu_pkg::fault_e                fault;
    logic [3:0]                     be_base;
    logic [mem_ops_pkg::DATA_W-1:0] wdata_base;
    logic                           last_mem;
    logic                           last_mem_d;
    logic [IDX_W-1:0]               last_idx;
    logic [IDX_W-1:0]               last_idx_d;
    logic                           hit_last;
    logic                           hit_last_d;

    assign phys = trans_en_i ? paddr_i.word : vaddr_i;
    assign set_idx = phys[OFF_W +: IDX_W];

    always_comb begin
        load_op = 1'b0;
        store_op = 1'b0;
        size = mem_ops_pkg::SZ_WORD;
        case (op_i)
            mem_ops_pkg::OP_LD_B, mem_ops_pkg::OP_LD_BU: begin
                load_op = 1'b1;
                size = mem_ops_pkg::SZ_BYTE;
            end
            mem_ops_pkg::OP_LD_H, mem_ops_pkg::OP_LD_HU: begin
                load_op = 1'b1;
                size = mem_ops_pkg::SZ_HALF;
            end
            mem_ops_pkg::OP_LD_W, mem_ops_pkg::OP_LL: load_op = 1'b1;
            mem_ops_pkg::OP_ST_B: begin
                store_op = 1'b1;
                size = mem_ops_pkg::SZ_BYTE;
            end
            mem_ops_pkg::OP_ST_H: begin
                store_op = 1'b1;
                size = mem_ops_pkg::SZ_HALF;
            end
            mem_ops_pkg::OP_ST_W: store_op = 1'b1;
            // A failed SC never touches memory
            mem_ops_pkg::OP_SC: store_op = llbit_i;
            default: ;
        endcase
    end

    assign access = valid_i & (load_op | store_op);

    always_comb begin
        fault = mmu_pkg::FLT_NONE;
        if (access && trans_en_i) begin
            if (plv_i == 2'd3 && vaddr_i[31]) begin
                fault = mmu_pkg::FLT_ADEM;
            end else if (!found_i) begin
                fault = mmu_pkg::FLT_TLBR;
            end else if (!tlb_v_i) begin
                fault = load_op ? mmu_pkg::FLT_PIL : mmu_pkg::FLT_PIS;
            end else if (plv_i > tlb_plv_i) begin
                fault = mmu_pkg::FLT_PPI;
            end else if (store_op && !tlb_d_i) begin
                fault = mmu_pkg::FLT_PME;
            end
        end
    end

    // Same-set hold-off over the two previous accepted accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            last_mem <= 1'b0;
            last_idx <= '0;
        end else if (access && advance_i) begin
            last_mem <= 1'b1;
            last_idx <= set_idx;
        end else if (ram_ready_i) begin
            last_mem <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mem_d <= 1'b0;
            last_idx_d <= '0;
        end else begin
            last_mem_d <= last_mem;
            last_idx_d <= last_idx;
        end
    end

    assign hit_last = last_mem & (last_idx == set_idx);
    assign hit_last_d = last_mem_d & (last_idx_d == set_idx);
    assign advance_ready_o = access ? (ram_ready_i & ~hit_last & ~hit_last_d) : 1'b1;

    always_comb begin
        case (size)
            mem_ops_pkg::SZ_BYTE: begin
                be_base = 4'b0001;
                wdata_base = {24'b0, store_data_i[7:0]};
            end
            mem_ops_pkg::SZ_HALF: begin
                be_base = 4'b0011;
                wdata_base = {16'b0, store_data_i[15:0]};
            end
            default: begin
                be_base = 4'b1111;
                wdata_base = store_data_i;
            end
        endcase
    end

    assign req_en_o = advance_i & access & ram_ready_i & (fault == mmu_pkg::FLT_NONE);
    assign req_we_o = store_op;
    assign req_be_o = be_base << phys[1:0];
    assign req_wdata_o = wdata_base << {phys[1:0], 3'b000};
    assign req_addr_o = phys[31:2];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            s_valid_o <= 1'b0;
        end else begin
            // Bubble while stalled
            s_valid_o <= advance_i & valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            s_op_o <= op_i;
            s_addr_lo_o <= phys[1:0];
            s_waddr_o <= waddr_i;
            s_fault_o <= fault;
            if (op_i == mem_ops_pkg::OP_SC) begin
                s_wreg_o <= 1'b1;
                s_wdata_o <= {{(mem_ops_pkg::DATA_W-1){1'b0}}, llbit_i};
            end else begin
                s_wreg_o <= wreg_i;
                s_wdata_o <= store_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int DEPTH = 256
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_en_i,
    input  wire logic        we_i,
    input  wire logic [3:0]  be_i,
    input  wire logic [29:0] addr_i,
    input  wire logic [31:0] wdata_i,
    output logic             ready_o,
    output logic [31:0]      rdata_o
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] widx;
    logic          busy;

    assign widx = addr_i[AW-1:0];
    assign ready_o = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (req_en_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Write takes the array for one extra cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= req_en_i & we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_en_i && !we_i) begin
            rdata_o <= mem[widx];
        end
    end

endmodule

`default_nettype wire

// File: hw/mem2_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem2_stage (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               s_valid_i,
    input  mem_ops_pkg::op_e                        s_op_i,
    input  wire logic [1:0]                         s_addr_lo_i,
    input  wire logic [mem_ops_pkg::REG_ADDR_W-1:0] s_waddr_i,
    input  wire logic                               s_wreg_i,
    input  wire logic [mem_ops_pkg::DATA_W-1:0]     s_wdata_i,
    input  mmu_pkg::fault_e                         s_fault_i,
    input  wire logic [31:0]                        rdata_i,
    output logic                                    llbit_o,
    output logic                                    wb_valid_o,
    output logic [mem_ops_pkg::REG_ADDR_W-1:0]      wb_waddr_o,
    output logic [mem_ops_pkg::DATA_W-1:0]          wb_wdata_o,
    output logic                                    wb_wreg_o,
    output mmu_pkg::fault_e                         wb_fault_o
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        ok;
    logic        ll_upd;
    logic        ll_next;
    logic        llbit_q;

    assign ld_byte = rdata_i[{s_addr_lo_i, 3'b000} +: 8];
    assign ld_half = s_addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (s_op_i)
            mem_ops_pkg::OP_LD_B:  wb_wdata_o = {{24{ld_byte[7]}}, ld_byte};
            mem_ops_pkg::OP_LD_BU: wb_wdata_o = {24'b0, ld_byte};
            mem_ops_pkg::OP_LD_H:  wb_wdata_o = {{16{ld_half[15]}}, ld_half};
            mem_ops_pkg::OP_LD_HU: wb_wdata_o = {16'b0, ld_half};
            mem_ops_pkg::OP_LD_W, mem_ops_pkg::OP_LL: wb_wdata_o = rdata_i;
            default: wb_wdata_o = s_wdata_i;
        endcase
    end

    assign ok = s_valid_i & (s_fault_i == mmu_pkg::FLT_NONE);

    assign wb_valid_o = s_valid_i;
    assign wb_waddr_o = s_waddr_i;
    assign wb_wreg_o = ok & s_wreg_i;
    assign wb_fault_o = s_fault_i;

    // LL sets, SC clears
    assign ll_upd = ok & (s_op_i == mem_ops_pkg::OP_LL || s_op_i == mem_ops_pkg::OP_SC);
    assign ll_next = (s_op_i == mem_ops_pkg::OP_LL);

    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_q <= 1'b0;
        end else if (ll_upd) begin
            llbit_q <= ll_next;
        end
    end

    // mem1 sees the value the instruction in the stage register leaves behind
    assign llbit_o = ll_upd ? ll_next : llbit_q;

endmodule

`default_nettype wire

// File: hw/mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int DMEM_DEPTH = 256,
    parameter int LINE_BYTES = 16,
    parameter int NSET = 64
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               instr_valid_i,
    input  mem_ops_pkg::op_e                        op_i,
    input  wire logic [31:0]                        vaddr_i,
    input  wire logic [mem_ops_pkg::DATA_W-1:0]     store_data_i,
    input  wire logic [mem_ops_pkg::REG_ADDR_W-1:0] waddr_i,
    input  wire logic                               wreg_i,
    input  mmu_pkg::plv_t                           plv_i,
    input  wire logic                               trans_en_i,
    input  wire logic                               tlb_we_i,
    input  wire logic [$clog2(TLB_ENTRIES)-1:0]     tlb_idx_i,
    input  wire logic [mmu_pkg::VPPN_W-1:0]         tlb_vppn_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]          tlb_ppn_i,
    input  wire logic                               tlb_v_i,
    input  wire logic                               tlb_d_i,
    input  mmu_pkg::plv_t                           tlb_plv_i,
    input  wire logic                               flush_i,
    output logic                                    ready_o,
    output logic                                    wb_valid_o,
    output logic [mem_ops_pkg::REG_ADDR_W-1:0]      wb_waddr_o,
    output logic [mem_ops_pkg::DATA_W-1:0]          wb_wdata_o,
    output logic                                    wb_wreg_o,
    output mmu_pkg::fault_e                         wb_fault_o
);

    mmu_pkg::paddr_u                    paddr;
    logic                               found;
    logic                               pg_v;
    logic                               pg_d;
    mmu_pkg::plv_t                      pg_plv;
    logic                               advance;
    logic                               llbit;
    logic                               ram_ready;
    logic                               req_en;
    logic                               req_we;
    logic [3:0]                         req_be;
    logic [29:0]                        req_addr;
    logic [31:0]                        req_wdata;
    logic [31:0]                        rdata;
    logic                               s_valid;
    mem_ops_pkg::op_e                   s_op;
    logic [1:0]                         s_addr_lo;
    logic [mem_ops_pkg::REG_ADDR_W-1:0] s_waddr;
    logic                               s_wreg;
    logic [mem_ops_pkg::DATA_W-1:0]     s_wdata;
    mmu_pkg::fault_e                    s_fault;

    assign ready_o = advance;

    tlb_lookup #(.ENTRIES(TLB_ENTRIES)) u_tlb (
        .clk(clk), .rst(rst), .vaddr_i(vaddr_i),
        .we_i(tlb_we_i), .idx_i(tlb_idx_i), .vppn_i(tlb_vppn_i), .ppn_i(tlb_ppn_i),
        .v_i(tlb_v_i), .d_i(tlb_d_i), .plv_i(tlb_plv_i),
        .paddr_o(paddr), .found_o(found), .v_o(pg_v), .d_o(pg_d), .plv_o(pg_plv)
    );

    mem1_stage #(.LINE_BYTES(LINE_BYTES), .NSET(NSET)) u_mem1 (
        .clk(clk), .rst(rst), .flush_i(flush_i),
        .advance_i(advance), .advance_ready_o(advance),
        .valid_i(instr_valid_i), .op_i(op_i), .vaddr_i(vaddr_i),
        .store_data_i(store_data_i), .waddr_i(waddr_i), .wreg_i(wreg_i),
        .plv_i(plv_i), .trans_en_i(trans_en_i), .paddr_i(paddr), .found_i(found),
        .tlb_v_i(pg_v), .tlb_d_i(pg_d), .tlb_plv_i(pg_plv),
        .llbit_i(llbit), .ram_ready_i(ram_ready),
        .req_en_o(req_en), .req_we_o(req_we), .req_be_o(req_be),
        .req_addr_o(req_addr), .req_wdata_o(req_wdata),
        .s_valid_o(s_valid), .s_op_o(s_op), .s_addr_lo_o(s_addr_lo),
        .s_waddr_o(s_waddr), .s_wreg_o(s_wreg), .s_wdata_o(s_wdata), .s_fault_o(s_fault)
    );

    data_ram #(.DEPTH(DMEM_DEPTH)) u_ram (
        .clk(clk), .rst(rst), .req_en_i(req_en), .we_i(req_we), .be_i(req_be),
        .addr_i(req_addr), .wdata_i(req_wdata), .ready_o(ram_ready), .rdata_o(rdata)
    );

    mem2_stage u_mem2 (
        .clk(clk), .rst(rst),
        .s_valid_i(s_valid), .s_op_i(s_op), .s_addr_lo_i(s_addr_lo),
        .s_waddr_i(s_waddr), .s_wreg_i(s_wreg), .s_wdata_i(s_wdata), .s_fault_i(s_fault),
        .rdata_i(rdata), .llbit_o(llbit),
        .wb_valid_o(wb_valid_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o),
        .wb_wreg_o(wb_wreg_o), .wb_fault_o(wb_fault_o)
    );

endmodule

`default_nettype wire

// File: bench/mem_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mem1_asserts (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      flush_i,
    input  wire logic      ready_i,
    input  wire logic      ram_ready_i,
    input  wire logic      hold_i,
    input  wire logic      req_en_i,
    input  wire logic      req_we_i,
    input  wire logic      trans_en_i,
    input  wire logic      va_msb_i,
    input  mmu_pkg::plv_t  plv_i,
    input  wire logic      found_i,
    input  wire logic      pg_v_i,
    input  wire logic      pg_d_i,
    input  mmu_pkg::plv_t  pg_plv_i,
    input  wire logic      s_valid_i
);

    int fail_count = 0;

    // Page checks taken straight from the TLB result
    property no_req_on_fault;
        @(posedge clk) disable iff (rst)
            req_en_i && trans_en_i |-> found_i && pg_v_i && (plv_i <= pg_plv_i)
                && !(plv_i == 2'd3 && va_msb_i) && (pg_d_i || !req_we_i);
    endproperty

    // A request moves the instruction into the stage register
    property req_needs_advance;
        @(posedge clk) disable iff (rst) req_en_i |=> s_valid_i || $past(flush_i);
    endproperty

    // No store busy period or same-set hold survives reset
    property ready_after_reset;
        @(posedge clk) $fell(rst) |-> ready_i && ram_ready_i && !hold_i;
    endproperty

    assert property (no_req_on_fault) else begin
        $error("memory request issued with a fault present");
        fail_count++;
    end
    assert property (req_needs_advance) else begin
        $error("memory request issued without advance");
        fail_count++;
    end
    assert property (ready_after_reset) else begin
        $error("advance_ready low right after reset");
        fail_count++;
    end

endmodule

bind mem1_stage mem1_asserts u_mem1_asserts (
    .clk(clk),
    .rst(rst),
    .flush_i(flush_i),
    .ready_i(advance_ready_o),
    .ram_ready_i(ram_ready_i),
    .hold_i(last_mem | last_mem_d),
    .req_en_i(req_en_o),
    .req_we_i(req_we_o),
    .trans_en_i(trans_en_i),
    .va_msb_i(vaddr_i[31]),
    .plv_i(plv_i),
    .found_i(found_i),
    .pg_v_i(tlb_v_i),
    .pg_d_i(tlb_d_i),
    .pg_plv_i(tlb_plv_i),
    .s_valid_i(s_valid_o)
);

`default_nettype wire

// File: bench/mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_tb;

    localparam int TLB_ENTRIES = 8;
    localparam int REC_W = 13;
    localparam int MAX_RECS = 64;

    logic                               clk;
    logic                               rst;
    logic                               instr_valid;
    mem_ops_pkg::op_e                   op;
    logic [31:0]                        vaddr;
    logic [31:0]                        store_data;
    logic [mem_ops_pkg::REG_ADDR_W-1:0] waddr;
    logic                               wreg;
    mmu_pkg::plv_t                      plv;
    logic                               trans_en;
    logic                               tlb_we;
    logic [$clog2(TLB_ENTRIES)-1:0]     tlb_idx;
    logic [mmu_pkg::VPPN_W-1:0]         tlb_vppn;
    logic [mmu_pkg::PPN_W-1:0]          tlb_ppn;
    logic                               tlb_v;
    logic                               tlb_d;
    mmu_pkg::plv_t                      tlb_plv;
    logic                               flush;
    logic                               ready;
    logic                               wb_valid;
    logic [mem_ops_pkg::REG_ADDR_W-1:0] wb_waddr;
    logic [31:0]                        wb_wdata;
    logic                               wb_wreg;
    mmu_pkg::fault_e                    wb_fault;

    logic [31:0] trace [MAX_RECS*REC_W];
    int          n_recs;
    int          cycle_limit;
    int          cycles;
    int          mismatches;
    int          other_errors;
    int          assert_fails;
    int          stalls;

    // Expected write-backs, oldest first
    logic [mem_ops_pkg::REG_ADDR_W-1:0] exp_waddr_q [$];
    logic                               exp_wreg_q [$];
    logic [31:0]                        exp_data_q [$];
    logic [2:0]                         exp_fault_q [$];

    mem_top #(
        .TLB_ENTRIES(TLB_ENTRIES),
        .DMEM_DEPTH(256),
        .LINE_BYTES(16),
        .NSET(64)
    ) UUT (
        .clk(clk), .rst(rst), .instr_valid_i(instr_valid), .op_i(op), .vaddr_i(vaddr),
        .store_data_i(store_data), .waddr_i(waddr), .wreg_i(wreg),
        .plv_i(plv), .trans_en_i(trans_en),
        .tlb_we_i(tlb_we), .tlb_idx_i(tlb_idx), .tlb_vppn_i(tlb_vppn), .tlb_ppn_i(tlb_ppn),
        .tlb_v_i(tlb_v), .tlb_d_i(tlb_d), .tlb_plv_i(tlb_plv), .flush_i(flush),
        .ready_o(ready), .wb_valid_o(wb_valid), .wb_waddr_o(wb_waddr),
        .wb_wdata_o(wb_wdata), .wb_wreg_o(wb_wreg), .wb_fault_o(wb_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int count_records();
        int n;
        n = 0;
        while (n < MAX_RECS && trace[n * REC_W] != 32'd2) begin
            n++;
        end
        if (n == MAX_RECS) begin
            $display("Trace file has no end record");
            other_errors++;
        end
        return n;
    endfunction

    task automatic write_tlb(input int r);
        logic [31:0] f [REC_W];
        for (int c = 0; c < REC_W; c++) begin
            f[c] = trace[r * REC_W + c];
        end
        instr_valid = 1'b0;
        tlb_we = 1'b1;
        tlb_idx = f[1][$clog2(TLB_ENTRIES)-1:0];
        tlb_vppn = f[2][mmu_pkg::VPPN_W-1:0];
        tlb_ppn = f[3][mmu_pkg::PPN_W-1:0];
        tlb_v = f[4][0];
        tlb_d = f[5][0];
        tlb_plv = f[6][1:0];
        @(posedge clk);
        #2;
        tlb_we = 1'b0;
    endtask

    // Holds the instruction until an edge sees ready_o high
    task automatic run_instr(input int r);
        logic [31:0] f [REC_W];
        logic        accepted;
        accepted = 1'b0;
        for (int c = 0; c < REC_W; c++) begin
            f[c] = trace[r * REC_W + c];
        end
        instr_valid = 1'b1;
        op = mem_ops_pkg::op_e'(f[1][3:0]);
        vaddr = f[2];
        store_data = f[3];
        waddr = f[4][mem_ops_pkg::REG_ADDR_W-1:0];
        wreg = f[5][0];
        plv = f[6][1:0];
        trans_en = f[7][0];
        flush = f[8][0];
        if (f[9][0]) begin
            exp_waddr_q.push_back(f[4][mem_ops_pkg::REG_ADDR_W-1:0]);
            exp_wreg_q.push_back(f[10][0]);
            exp_data_q.push_back(f[11]);
            exp_fault_q.push_back(f[12][2:0]);
        end
        while (!accepted) begin
            @(negedge clk);
            accepted = ready;
            if (!ready) begin
                stalls++;
            end
            @(posedge clk);
        end
        #2;
        flush = 1'b0;
    endtask

    task automatic check_writeback();
        logic [mem_ops_pkg::REG_ADDR_W-1:0] e_waddr;
        logic                               e_wreg;
        logic [31:0]                        e_data;
        logic [2:0]                         e_fault;
        if (exp_wreg_q.size() == 0) begin
            $display("Write-back at %0t with no instruction outstanding", $time);
            other_errors++;
        end else begin
            e_waddr = exp_waddr_q.pop_front();
            e_wreg = exp_wreg_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_fault = exp_fault_q.pop_front();
            assert (wb_waddr == e_waddr) else begin
                $display("MISMATCH at %0t: waddr %0d, expected %0d", $time, wb_waddr, e_waddr);
                mismatches++;
            end
            assert (wb_wreg == e_wreg) else begin
                $display("MISMATCH at %0t: r%0d wreg %0b, expected %0b",
                         $time, e_waddr, wb_wreg, e_wreg);
                mismatches++;
            end
            assert (wb_fault == e_fault) else begin
                $display("MISMATCH at %0t: r%0d fault %0d, expected %0d",
                         $time, e_waddr, wb_fault, e_fault);
                mismatches++;
            end
            // Data only counts when the register is written
            if (e_wreg) begin
                assert (wb_wdata == e_data) else begin
                    $display("MISMATCH at %0t: r%0d data %h, expected %h",
                             $time, e_waddr, wb_wdata, e_data);
                    mismatches++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            check_writeback();
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the trace did not finish", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        op = mem_ops_pkg::OP_NOP;
        vaddr = '0;
        store_data = '0;
        waddr = '0;
        wreg = 1'b0;
        plv = '0;
        trans_en = 1'b0;
        tlb_we = 1'b0;
        tlb_idx = '0;
        tlb_vppn = '0;
        tlb_ppn = '0;
        tlb_v = 1'b0;
        tlb_d = 1'b0;
        tlb_plv = '0;
        flush = 1'b0;
        mismatches = 0;
        other_errors = 0;
        assert_fails = 0;
        stalls = 0;
        $readmemh("bench/mem_trace.txt", trace);
        n_recs = count_records();
        cycle_limit = 4 * n_recs + 100;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < n_recs; r++) begin
            if (trace[r * REC_W] == 32'd0) begin
                write_tlb(r);
            end else begin
                run_instr(r);
            end
        end
        instr_valid = 1'b0;
        op = mem_ops_pkg::OP_NOP;
        while (exp_wreg_q.size() != 0) begin
            @(posedge clk);
        end
        // A few idle cycles to catch stray write-backs
        repeat (4) @(posedge clk);
        assert (stalls > 0) else begin
            $display("ready_o never dropped while the trace ran");
            other_errors++;
        end
        assert_fails = UUT.u_mem1.u_mem1_asserts.fail_count;
        $display("Errors: %0d mismatches, %0d assertion, %0d other (%0d stall cycles seen)",
                 mismatches, assert_fails, other_errors, stalls);
        if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/mem_trace.txt
// 0 = TLB write: idx vppn ppn v d plv, padded with zeros; 2 = end of trace
// 1 = instr: op vaddr sdata waddr wreg plv trans flush exp_wb exp_wreg exp_data exp_fault
0 0 00010 00020 1 1 3 0 0 0 0 00000000 0
0 1 00011 00021 0 1 3 0 0 0 0 00000000 0
0 2 00012 00022 1 1 0 0 0 0 0 00000000 0
0 3 00013 00023 1 0 3 0 0 0 0 00000000 0
// stores of each size, then loads of each size and sign
1 8 00010000 11223344 00 0 0 1 0 1 0 00000000 0
1 7 00010006 0000beef 00 0 0 1 0 1 0 00000000 0
1 6 00010009 000000a5 00 0 0 1 0 1 0 00000000 0
1 6 0001000b 0000007f 00 0 0 1 0 1 0 00000000 0
1 5 00010000 00000000 01 1 0 1 0 1 1 11223344 0
1 1 00010007 00000000 02 1 0 1 0 1 1 ffffffbe 0
1 2 00010007 00000000 03 1 0 1 0 1 1 000000be 0
1 3 00010006 00000000 04 1 0 1 0 1 1 ffffbeef 0
1 4 00010006 00000000 05 1 0 1 0 1 1 0000beef 0
1 1 00010009 00000000 06 1 0 1 0 1 1 ffffffa5 0
1 2 0001000b 00000000 07 1 0 1 0 1 1 0000007f 0
1 3 00010002 00000000 08 1 0 1 0 1 1 00001122 0
1 5 00010008 00000000 09 1 0 1 0 1 1 7f00a500 0
// faults: TLBR PIL PIS PPI PME ADEM, then the target word is still zero
1 8 00050100 deadbeef 00 0 0 1 0 1 0 00000000 2
1 5 00011100 00000000 0a 1 0 1 0 1 0 00000000 3
1 8 00011100 deadbeef 00 0 0 1 0 1 0 00000000 4
1 8 00012100 deadbeef 00 0 3 1 0 1 0 00000000 5
1 8 00013100 deadbeef 00 0 0 1 0 1 0 00000000 6
1 8 80010100 deadbeef 00 0 3 1 0 1 0 00000000 1
1 5 00013100 00000000 0b 1 0 1 0 1 1 00000000 0
// LL then two SCs
1 8 00010200 00000055 00 0 0 1 0 1 0 00000000 0
1 9 00010200 00000000 0c 1 0 1 0 1 1 00000055 0
1 a 00010200 12345678 0d 1 0 1 0 1 1 00000001 0
1 a 00010200 9abcdef0 0e 1 0 1 0 1 1 00000000 0
1 5 00010200 00000000 0f 1 0 1 0 1 1 12345678 0
// store then load, translation off, flush
1 8 00010310 cafef00d 00 0 0 1 0 1 0 00000000 0
1 5 00010310 00000000 10 1 0 1 0 1 1 cafef00d 0
1 7 00010322 00001234 00 0 0 1 0 1 0 00000000 0
1 4 00010322 00000000 11 1 0 1 0 1 1 00001234 0
1 8 000103f0 a5a5a5a5 00 0 0 1 0 1 0 00000000 0
1 5 00010000 00000000 12 1 0 1 0 1 1 11223344 0
1 5 000103f0 00000000 13 1 0 1 0 1 1 a5a5a5a5 0
1 5 00000310 00000000 14 1 0 0 0 1 1 cafef00d 0
1 5 00010000 00000000 15 1 0 1 1 0 0 00000000 0
1 5 00010310 00000000 16 1 0 1 0 1 1 cafef00d 0
2 0 00000000 00000000 00 0 0 0 0 0 0 00000000 0

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module mem_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vmem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: filelist.f
hw/mem_ops_pkg.sv
hw/mmu_pkg.sv
hw/tlb_lookup.sv
hw/mem1_stage.sv
hw/data_ram.sv
hw/mem2_stage.sv
hw/mem_top.sv
bench/mem_asserts.sv
bench/mem_tb.sv
